// File: build.f
hdl/cache_pkg.sv
hdl/req_slot.sv
hdl/cache_array.sv
hdl/core_protocol.sv
hdl/snoop_protocol.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
sim/tb_clock.sv
sim/cache_assertions.sv
sim/cache_tb.sv

// File: hdl/cache_array.sv
`default_nettype none

module cache_array (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cache_pkg::blk_idx_t    core_idx,
  output cache_pkg::cache_line_t core_line,
  input  cache_pkg::blk_idx_t    snp_idx,
  output cache_pkg::cache_line_t snp_line,
  input  logic                   wr_en,
  input  cache_pkg::blk_idx_t    wr_idx,
  input  cache_pkg::cache_line_t wr_line
);
  import cache_pkg::*;

  blk_state_e state_q [NUM_BLK];
  blk_tag_t   tag_q   [NUM_BLK];
  blk_data_t  data_q  [NUM_BLK];

  // --------------------------------------
  // line state
  // --------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_BLK; i++) begin
        state_q[i] <= INVALID;
      end
    end else if (wr_en) begin
      state_q[wr_idx] <= wr_line.state;
    end
  end

  // tag and data
  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_q[wr_idx]  <= wr_line.tag;
      data_q[wr_idx] <= wr_line.data;
    end
  end

  // --------------------------------------
  // read ports
  // --------------------------------------
  always_comb begin
    core_line.state = state_q[core_idx];
    core_line.tag   = tag_q[core_idx];
    core_line.data  = data_q[core_idx];
  end

  always_comb begin
    snp_line.state = state_q[snp_idx];
    snp_line.tag   = tag_q[snp_idx];
    snp_line.data  = data_q[snp_idx];
  end

endmodule

`default_nettype wire

// File: hdl/cache_ctrl.sv
`default_nettype none

module cache_ctrl (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    core_full,
  input  cache_pkg::core_req_t    core_req,
  output logic                    core_release,
  input  logic                    snp_full,
  input  cache_pkg::snp_req_t     snp_req,
  output logic                    snp_release,
  input  cache_pkg::cache_line_t  core_line,
  input  cache_pkg::cache_line_t  snp_line,
  input  cache_pkg::core_action_t action,
  input  cache_pkg::blk_state_e   snp_next_state,
  input  cache_pkg::snp_rsp_e     snp_code,
  output logic                    wr_en,
  output cache_pkg::blk_idx_t     wr_idx,
  output cache_pkg::cache_line_t  wr_line,
  output logic                    core_rsp_valid,
  output cache_pkg::core_rsp_t    core_rsp,
  input  logic                    core_rsp_ready,
  output logic                    dn_req_valid,
  output cache_pkg::dn_req_t      dn_req,
  input  logic                    dn_req_ready,
  input  logic                    dn_rsp_valid,
  input  cache_pkg::blk_data_t    dn_rsp,
  output logic                    dn_rsp_ready,
  output logic                    snp_rsp_valid,
  output cache_pkg::snp_rsp_t     snp_rsp,
  input  logic                    snp_rsp_ready
);
  import cache_pkg::*;

  typedef enum logic [2:0] {
    CS_IDLE,
    CS_WB_REQ,
    CS_WB_WAIT,
    CS_FETCH_REQ,
    CS_FETCH_WAIT,
    CS_CORE_RSP,
    CS_SNP_RSP
  } ctrl_state_e;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  blk_data_t   fill_q;
  blk_data_t   rd_data;
  blk_idx_t    core_idx;
  blk_tag_t    core_tag;
  logic        rd_hit;

  assign core_idx = core_req.addr[IDX_WIDTH-1:0];
  assign core_tag = core_req.addr[ADDR_WIDTH-1:IDX_WIDTH];
  assign rd_hit   = action.hit && (core_req.op == CORE_RD);
  // line content seen by the core from the array or the fill
  assign rd_data  = action.hit ? core_line.data : fill_q;

  // --------------------------------------
  // sequencing
  // --------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= CS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      CS_IDLE: begin
        // snoops win over core requests
        if (snp_full) begin
          state_d = CS_SNP_RSP;
        end else if (core_full) begin
          if (action.need_wb) begin
            state_d = CS_WB_REQ;
          end else if (action.need_dn) begin
            state_d = CS_FETCH_REQ;
          end else begin
            state_d = CS_CORE_RSP;
          end
        end
      end
      CS_WB_REQ:     if (dn_req_ready) state_d = CS_WB_WAIT;
      CS_WB_WAIT:    if (dn_rsp_valid) state_d = CS_FETCH_REQ;
      CS_FETCH_REQ:  if (dn_req_ready) state_d = CS_FETCH_WAIT;
      CS_FETCH_WAIT: if (dn_rsp_valid) state_d = CS_CORE_RSP;
      CS_CORE_RSP:   if (core_rsp_ready) state_d = CS_IDLE;
      CS_SNP_RSP:    if (snp_rsp_ready) state_d = CS_IDLE;
      default:       state_d = CS_IDLE;
    endcase
  end

  // fetched block, or upgrade ack
  always_ff @(posedge clk) begin
    if ((state_q == CS_FETCH_WAIT) && dn_rsp_valid) begin
      fill_q <= dn_rsp;
    end
  end

  // --------------------------------------
  // downstream channel
  // --------------------------------------
  assign dn_req_valid = (state_q == CS_WB_REQ) || (state_q == CS_FETCH_REQ);
  assign dn_rsp_ready = (state_q == CS_WB_WAIT) || (state_q == CS_FETCH_WAIT);

  always_comb begin
    dn_req.op   = action.dn_op;
    dn_req.addr = core_req.addr;
    dn_req.data = '0;
    if (state_q == CS_WB_REQ) begin
      // victim address rebuilt from stored tag
      dn_req.op   = DN_WB;
      dn_req.addr = {core_line.tag, core_idx};
      dn_req.data = core_line.data;
    end
  end

  // --------------------------------------
  // responses
  // --------------------------------------
  assign core_rsp_valid = (state_q == CS_CORE_RSP);
  assign core_release   = core_rsp_valid && core_rsp_ready;
  assign snp_rsp_valid  = (state_q == CS_SNP_RSP);
  assign snp_release    = snp_rsp_valid && snp_rsp_ready;

  always_comb begin
    core_rsp.data = (core_req.op == CORE_WR) ? '0 : rd_data;
  end

  always_comb begin
    snp_rsp.rsp  = snp_code;
    snp_rsp.data = (snp_code == SNP_DIRTY) ? snp_line.data : '0;
  end

  // array update on the response handshake
  always_comb begin
    wr_en         = core_release && !rd_hit;
    wr_idx        = core_idx;
    wr_line.state = action.final_state;
    wr_line.tag   = core_tag;
    wr_line.data  = (core_req.op == CORE_WR) ? core_req.data : rd_data;
    if (state_q == CS_SNP_RSP) begin
      wr_en         = snp_release && (snp_code != SNP_MISS);
      wr_idx        = snp_req.addr[IDX_WIDTH-1:0];
      wr_line.state = snp_next_state;
      wr_line.tag   = snp_line.tag;
      wr_line.data  = snp_line.data;
    end
  end

endmodule

`default_nettype wire

// File: hdl/cache_pkg.sv
`default_nettype none

package cache_pkg;

  // --------------------------------------
  // sizes
  // --------------------------------------
  localparam int ADDR_WIDTH = 8;
  localparam int NUM_BLK    = 8;
  localparam int IDX_WIDTH  = $clog2(NUM_BLK);
  localparam int TAG_WIDTH  = ADDR_WIDTH - IDX_WIDTH;
  localparam int BLK_WIDTH  = 32;

  typedef logic [ADDR_WIDTH-1:0] blk_addr_t;
  typedef logic [IDX_WIDTH-1:0]  blk_idx_t;
  typedef logic [TAG_WIDTH-1:0]  blk_tag_t;
  typedef logic [BLK_WIDTH-1:0]  blk_data_t;

  // --------------------------------------
  // encodings
  // --------------------------------------
  // bit 0 set means the line is valid
  typedef enum logic [1:0] {
    INVALID  = 2'b00,
    SHARED   = 2'b01,
    MODIFIED = 2'b11
  } blk_state_e;

  typedef enum logic {CORE_RD, CORE_WR} core_op_e;

  typedef enum logic [1:0] {DN_RD, DN_RFO, DN_UPG, DN_WB} dn_op_e;

  typedef enum logic {SNP_RD, SNP_INV} snp_op_e;

  typedef enum logic [1:0] {SNP_MISS, SNP_CLEAN, SNP_DIRTY} snp_rsp_e;

  // --------------------------------------
  // channel payloads
  // --------------------------------------
  typedef struct packed {
    core_op_e  op;
    blk_addr_t addr;
    blk_data_t data;
  } core_req_t;

  // zero for a write acknowledgement
  typedef struct packed {
    blk_data_t data;
  } core_rsp_t;

  // data only meaningful for DN_WB
  typedef struct packed {
    dn_op_e    op;
    blk_addr_t addr;
    blk_data_t data;
  } dn_req_t;

  typedef struct packed {
    snp_op_e   op;
    blk_addr_t addr;
  } snp_req_t;

  // data only meaningful with SNP_DIRTY
  typedef struct packed {
    snp_rsp_e  rsp;
    blk_data_t data;
  } snp_rsp_t;

  typedef struct packed {
    blk_state_e state;
    blk_tag_t   tag;
    blk_data_t  data;
  } cache_line_t;

  // core table decision
  typedef struct packed {
    logic       hit;
    logic       need_wb;
    dn_op_e     dn_op;
    logic       need_dn;
    blk_state_e final_state;
  } core_action_t;

endpackage

`default_nettype wire

// File: hdl/cache_top.sv
`default_nettype none

module cache_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 core_req_valid,
  input  cache_pkg::core_req_t core_req,
  output logic                 core_req_ready,
  output logic                 core_rsp_valid,
  output cache_pkg::core_rsp_t core_rsp,
  input  logic                 core_rsp_ready,
  output logic                 dn_req_valid,
  output cache_pkg::dn_req_t   dn_req,
  input  logic                 dn_req_ready,
  input  logic                 dn_rsp_valid,
  input  cache_pkg::blk_data_t dn_rsp,
  output logic                 dn_rsp_ready,
  input  logic                 snp_req_valid,
  input  cache_pkg::snp_req_t  snp_req,
  output logic                 snp_req_ready,
  output logic                 snp_rsp_valid,
  output cache_pkg::snp_rsp_t  snp_rsp,
  input  logic                 snp_rsp_ready
);
  import cache_pkg::*;

  logic         core_full;
  logic         core_release;
  core_req_t    core_buf;
  logic         snp_full;
  logic         snp_release;
  snp_req_t     snp_buf;
  cache_line_t  core_line;
  cache_line_t  snp_line;
  core_action_t action;
  blk_state_e   snp_next_state;
  snp_rsp_e     snp_code;
  logic         wr_en;
  blk_idx_t     wr_idx;
  cache_line_t  wr_line;

  // --------------------------------------
  // inbound buffers
  // --------------------------------------
  req_slot #(.payload_t(core_req_t)) core_slot (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (core_req_valid),
    .in_data    (core_req),
    .in_ready   (core_req_ready),
    .do_release (core_release),
    .full       (core_full),
    .data       (core_buf)
  );

  req_slot #(.payload_t(snp_req_t)) snp_slot (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (snp_req_valid),
    .in_data    (snp_req),
    .in_ready   (snp_req_ready),
    .do_release (snp_release),
    .full       (snp_full),
    .data       (snp_buf)
  );

  // --------------------------------------
  // storage and lookup
  // --------------------------------------
  cache_array u_array (
    .clk       (clk),
    .rst_n     (rst_n),
    .core_idx  (core_buf.addr[IDX_WIDTH-1:0]),
    .core_line (core_line),
    .snp_idx   (snp_buf.addr[IDX_WIDTH-1:0]),
    .snp_line  (snp_line),
    .wr_en     (wr_en),
    .wr_idx    (wr_idx),
    .wr_line   (wr_line)
  );

  core_protocol u_core_prot (
    .req    (core_buf),
    .line   (core_line),
    .action (action)
  );

  snoop_protocol u_snp_prot (
    .req        (snp_buf),
    .line       (snp_line),
    .next_state (snp_next_state),
    .rsp        (snp_code)
  );

  cache_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .core_full      (core_full),
    .core_req       (core_buf),
    .core_release   (core_release),
    .snp_full       (snp_full),
    .snp_req        (snp_buf),
    .snp_release    (snp_release),
    .core_line      (core_line),
    .snp_line       (snp_line),
    .action         (action),
    .snp_next_state (snp_next_state),
    .snp_code       (snp_code),
    .wr_en          (wr_en),
    .wr_idx         (wr_idx),
    .wr_line        (wr_line),
    .core_rsp_valid (core_rsp_valid),
    .core_rsp       (core_rsp),
    .core_rsp_ready (core_rsp_ready),
    .dn_req_valid   (dn_req_valid),
    .dn_req         (dn_req),
    .dn_req_ready   (dn_req_ready),
    .dn_rsp_valid   (dn_rsp_valid),
    .dn_rsp         (dn_rsp),
    .dn_rsp_ready   (dn_rsp_ready),
    .snp_rsp_valid  (snp_rsp_valid),
    .snp_rsp        (snp_rsp),
    .snp_rsp_ready  (snp_rsp_ready)
  );

endmodule

`default_nettype wire

// File: hdl/core_protocol.sv
`default_nettype none

module core_protocol (
  input  cache_pkg::core_req_t    req,
  input  cache_pkg::cache_line_t  line,
  output cache_pkg::core_action_t action
);
  import cache_pkg::*;

  blk_tag_t req_tag;
  logic     hit;

  assign req_tag = req.addr[ADDR_WIDTH-1:IDX_WIDTH];
  // valid state and matching tag
  assign hit     = line.state[0] && (line.tag == req_tag);

  always_comb begin
    action.hit         = hit;
    action.need_wb     = 1'b0;
    action.need_dn     = 1'b0;
    action.dn_op       = DN_RD;
    action.final_state = line.state;

    if (hit) begin
      // read hit keeps the line as is
      if (req.op == CORE_WR) begin
        action.final_state = MODIFIED;
        if (line.state == SHARED) begin
          action.need_dn = 1'b1;
          action.dn_op   = DN_UPG;
        end
      end
    end else begin
      // dirty victim goes out first
      action.need_wb = (line.state == MODIFIED);
      action.need_dn = 1'b1;
      if (req.op == CORE_WR) begin
        action.dn_op       = DN_RFO;
        action.final_state = MODIFIED;
      end else begin
        action.dn_op       = DN_RD;
        action.final_state = SHARED;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/req_slot.sv
`default_nettype none

module req_slot #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  input  logic     do_release,
  output logic     full,
  output payload_t data
);

  logic accept;

  // ready only while the slot is empty
  assign in_ready = !full;
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (accept) begin
      full <= 1'b1;
    end else if (do_release) begin
      full <= 1'b0;
    end
  end

  // payload held until released
  always_ff @(posedge clk) begin
    if (accept) begin
      data <= in_data;
    end
  end

endmodule

`default_nettype wire

// File: hdl/snoop_protocol.sv
`default_nettype none

module snoop_protocol (
  input  cache_pkg::snp_req_t    req,
  input  cache_pkg::cache_line_t line,
  output cache_pkg::blk_state_e  next_state,
  output cache_pkg::snp_rsp_e    rsp
);
  import cache_pkg::*;

  blk_tag_t req_tag;
  logic     hit;

  assign req_tag = req.addr[ADDR_WIDTH-1:IDX_WIDTH];
  assign hit     = line.state[0] && (line.tag == req_tag);

  always_comb begin
    if (!hit) begin
      // miss leaves the line unchanged
      next_state = line.state;
      rsp        = SNP_MISS;
    end else begin
      if (line.state == MODIFIED) begin
        rsp = SNP_DIRTY;
      end else begin
        rsp = SNP_CLEAN;
      end

      if (req.op == SNP_RD) begin
        next_state = SHARED;
      end else begin
        next_state = INVALID;
      end
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cache_tb -f build.f -o cache_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/cache_sim +verilator+error+limit+10000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Finished with no errors$" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

// File: sim/cache_assertions.sv
`default_nettype none

module cache_assertions (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 core_req_valid,
  input cache_pkg::core_req_t core_req,
  input logic                 core_req_ready,
  input logic                 core_rsp_valid,
  input cache_pkg::core_rsp_t core_rsp,
  input logic                 core_rsp_ready,
  input logic                 dn_req_valid,
  input cache_pkg::dn_req_t   dn_req,
  input logic                 dn_req_ready,
  input logic                 dn_rsp_ready,
  input logic                 snp_req_valid,
  input cache_pkg::snp_req_t  snp_req,
  input logic                 snp_req_ready,
  input logic                 snp_rsp_valid,
  input cache_pkg::snp_rsp_t  snp_rsp,
  input logic                 snp_rsp_ready
);
  timeunit 1ns;
  timeprecision 100ps;
  import cache_pkg::*;

  blk_data_t  shadow  [256];
  logic       dirty   [256];
  // 0 unknown, 1 next snoop misses, 2 next snoop is clean
  logic [1:0] snp_exp [256];
  core_req_t  pend_core = '0;
  snp_req_t   pend_snp = '0;
  blk_data_t  exp_core, exp_wb, exp_snp;
  logic       own_core, own_snp;
  logic [1:0] prev_snp;
  int         fail_cnt = 0;

  initial begin
    for (int i = 0; i < 256; i++) begin
      shadow[i]  = {4{i[7:0]}} ^ 32'h5A5A5A5A;
      dirty[i]   = 1'b0;
      snp_exp[i] = 2'd0;
    end
  end

  // ----------------------------------------
  // shadow of the latest value per address
  // ----------------------------------------
  always @(posedge clk) begin
    if (core_req_valid && core_req_ready) pend_core <= core_req;
    if (snp_req_valid && snp_req_ready) pend_snp <= snp_req;
    if (core_rsp_valid && core_rsp_ready) begin
      // any other block on this index is gone now
      for (int a = 0; a < 256; a++) begin
        if (blk_idx_t'(a) == pend_core.addr[IDX_WIDTH-1:0]) begin
          if (blk_addr_t'(a) != pend_core.addr) dirty[a] <= 1'b0;
          snp_exp[a] <= 2'd0;
        end
      end
      if (pend_core.op == CORE_WR) begin
        shadow[pend_core.addr] <= pend_core.data;
        dirty[pend_core.addr]  <= 1'b1;
      end
    end
    if (snp_rsp_valid && snp_rsp_ready) begin
      dirty[pend_snp.addr] <= 1'b0;
      if (pend_snp.op == SNP_INV || snp_rsp.rsp == SNP_MISS) snp_exp[pend_snp.addr] <= 2'd1;
      else snp_exp[pend_snp.addr] <= 2'd2;
    end
  end

  always_comb begin
    exp_core = shadow[pend_core.addr];
    exp_wb   = shadow[dn_req.addr];
    exp_snp  = shadow[pend_snp.addr];
    own_core = dirty[pend_core.addr];
    own_snp  = dirty[pend_snp.addr];
    prev_snp = snp_exp[pend_snp.addr];
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------
  a_reset: assert property (@(posedge clk) $rose(rst_n) |-> !core_rsp_valid && !dn_req_valid
      && !snp_rsp_valid && !dn_rsp_ready && core_req_ready && snp_req_ready)
    else begin
      fail_cnt++;
      $error("outputs not idle right after reset");
    end

  a_rd_data: assert property (@(posedge clk) disable iff (!rst_n)
      core_rsp_valid && pend_core.op == CORE_RD |-> core_rsp.data == exp_core)
    else begin
      fail_cnt++;
      $error("mismatch at %0t: core_rsp.data expected %h got %h", $time, exp_core, core_rsp.data);
    end

  a_wb_data: assert property (@(posedge clk) disable iff (!rst_n)
      dn_req_valid && dn_req.op == DN_WB |-> dn_req.data == exp_wb)
    else begin
      fail_cnt++;
      $error("mismatch at %0t: dn_req.data expected %h got %h", $time, exp_wb, dn_req.data);
    end

  a_owned_wr: assert property (@(posedge clk) disable iff (!rst_n)
      !core_req_ready && pend_core.op == CORE_WR && own_core |-> !dn_req_valid)
    else begin
      fail_cnt++;
      $error("write hit on a modified line went downstream");
    end

  a_snp_dirty: assert property (@(posedge clk) disable iff (!rst_n)
      snp_rsp_valid && own_snp |-> snp_rsp.rsp == SNP_DIRTY && snp_rsp.data == exp_snp)
    else begin
      fail_cnt++;
      $error("mismatch at %0t: snp_rsp expected dirty %h got %0d %h",
             $time, exp_snp, snp_rsp.rsp, snp_rsp.data);
    end

  a_snp_again: assert property (@(posedge clk) disable iff (!rst_n)
      snp_rsp_valid && prev_snp != 2'd0 |->
      snp_rsp.rsp == ((prev_snp == 2'd1) ? SNP_MISS : SNP_CLEAN))
    else begin
      fail_cnt++;
      $error("mismatch at %0t: snp_rsp.rsp expected %0d got %0d",
             $time, (prev_snp == 2'd1) ? SNP_MISS : SNP_CLEAN, snp_rsp.rsp);
    end

  // held valid and payload under back-pressure
  a_core_hold: assert property (@(posedge clk) disable iff (!rst_n)
      core_rsp_valid && !core_rsp_ready |=> core_rsp_valid && $stable(core_rsp))
    else begin
      fail_cnt++;
      $error("core response dropped or changed before ready");
    end

  a_dn_hold: assert property (@(posedge clk) disable iff (!rst_n)
      dn_req_valid && !dn_req_ready |=> dn_req_valid && $stable(dn_req))
    else begin
      fail_cnt++;
      $error("downstream request dropped or changed before ready");
    end

  a_snp_hold: assert property (@(posedge clk) disable iff (!rst_n)
      snp_rsp_valid && !snp_rsp_ready |=> snp_rsp_valid && $stable(snp_rsp))
    else begin
      fail_cnt++;
      $error("snoop response dropped or changed before ready");
    end

endmodule

bind cache_top cache_assertions chk0 (.*);

`default_nettype wire

// File: sim/cache_tb.sv
`default_nettype none

module cache_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import cache_pkg::*;

  localparam int NUM_CORE = 300;
  localparam int NUM_SNP  = 60;
  localparam int TIMEOUT_CYCLES = 20 * (NUM_CORE + NUM_SNP);

  logic      clk, rst_n;
  logic      core_req_valid, core_req_ready, core_rsp_valid, core_rsp_ready;
  logic      dn_req_valid, dn_req_ready, dn_rsp_valid, dn_rsp_ready;
  logic      snp_req_valid, snp_req_ready, snp_rsp_valid, snp_rsp_ready;
  core_req_t core_req;
  core_rsp_t core_rsp;
  dn_req_t   dn_req;
  blk_data_t dn_rsp;
  snp_req_t  snp_req;
  snp_rsp_t  snp_rsp;

  blk_data_t   mem [256];
  blk_addr_t   snp_addr_q;
  dn_req_t     dn_q;
  int unsigned rnd_core, rnd_snp, rnd_dn, rnd_rdy;
  int          cycles;

  tb_clock clk_gen (.clk(clk), .rst_n(rst_n));

  cache_top dut0 (.*);

  function automatic int unsigned lcg(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // 3 tags on each of the 8 indexes
  function automatic blk_addr_t pick_addr(input int unsigned s);
    return blk_addr_t'(((s >> 16) % 3) * 8 + ((s >> 20) % 8));
  endfunction

  task automatic drive_core(input int n);
    for (int i = 0; i < n; i++) begin
      rnd_core = lcg(rnd_core);
      core_req.op   = ((rnd_core >> 24) & 1) ? CORE_WR : CORE_RD;
      core_req.addr = pick_addr(rnd_core);
      rnd_core = lcg(rnd_core);
      core_req.data = rnd_core;
      core_req_valid = 1'b1;
      @(negedge clk);
      while (!core_req_ready) @(negedge clk);
      @(posedge clk);
      #1 core_req_valid = 1'b0;
      repeat ((rnd_core >> 16) % 3) @(posedge clk);
      #1;
    end
  endtask

  task automatic drive_snoops(input int n);
    logic again;
    for (int i = 0; i < n; i++) begin
      rnd_snp = lcg(rnd_snp);
      // some snoops go straight back to the last address
      again = (i > 0) && (((rnd_snp >> 28) & 1) != 0);
      if (!again) begin
        repeat ((rnd_snp >> 16) % 30) @(posedge clk);
        #1;
      end
      rnd_snp = lcg(rnd_snp);
      snp_req.op   = ((rnd_snp >> 24) & 1) ? SNP_INV : SNP_RD;
      if (!again) begin
        snp_req.addr = pick_addr(rnd_snp);
      end
      snp_req_valid = 1'b1;
      @(negedge clk);
      while (!snp_req_ready) @(negedge clk);
      snp_addr_q = snp_req.addr;
      @(posedge clk);
      #1 snp_req_valid = 1'b0;
    end
  endtask

  // ----------------------------------------
  // downstream memory model
  // ----------------------------------------
  initial begin
    for (int i = 0; i < 256; i++) mem[i] = {4{i[7:0]}} ^ 32'h5A5A5A5A;
    forever begin
      @(negedge clk);
      if (dn_req_valid && dn_req_ready) begin
        dn_q = dn_req;
        @(posedge clk);
        #1;
        if (dn_q.op == DN_WB) mem[dn_q.addr] = dn_q.data;
        rnd_dn = lcg(rnd_dn);
        repeat ((rnd_dn >> 16) % 4) @(posedge clk);
        #1;
        dn_rsp_valid = 1'b1;
        // upgrade and writeback get a plain ack
        dn_rsp = (dn_q.op == DN_RD || dn_q.op == DN_RFO) ? mem[dn_q.addr] : '0;
        @(negedge clk);
        while (!dn_rsp_ready) @(negedge clk);
        @(posedge clk);
        #1 dn_rsp_valid = 1'b0;
      end
    end
  end

  // dirty snoop data lands in memory
  always @(negedge clk) begin
    if (snp_rsp_valid && snp_rsp_ready && snp_rsp.rsp == SNP_DIRTY) mem[snp_addr_q] = snp_rsp.data;
  end

  // outbound ready low about a quarter of the time
  always @(posedge clk) begin
    #1;
    rnd_rdy = lcg(rnd_rdy);
    core_rsp_ready = ((rnd_rdy >> 16) % 4) != 0;
    dn_req_ready   = ((rnd_rdy >> 20) % 4) != 0;
    snp_rsp_ready  = ((rnd_rdy >> 24) % 4) != 0;
  end

  // ----------------------------------------
  // run control
  // ----------------------------------------
  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
        $display("run timed out after %0d cycles with traffic still pending", cycles);
        $display("error counts: assertion failures %0d, timeouts 1", dut0.chk0.fail_cnt);
        $display("Finished with errors");
        $finish;
      end
    end
  end

  initial begin
    core_req_valid = 1'b0;
    core_req       = '0;
    core_rsp_ready = 1'b1;
    dn_req_ready   = 1'b1;
    dn_rsp_valid   = 1'b0;
    dn_rsp         = '0;
    snp_req_valid  = 1'b0;
    snp_req        = '0;
    snp_rsp_ready  = 1'b1;
    snp_addr_q     = '0;
    rnd_core = 32'd53643;
    rnd_snp  = lcg(32'd53643 + 1);
    rnd_dn   = lcg(32'd53643 + 2);
    rnd_rdy  = lcg(32'd53643 + 3);
    @(posedge rst_n);
    @(posedge clk);
    #1;
    fork
      drive_core(NUM_CORE);
      drive_snoops(NUM_SNP);
    join
    while (!(core_req_ready && snp_req_ready)) @(negedge clk);
    repeat (4) @(posedge clk);
    $display("error counts: assertion failures %0d, timeouts 0", dut0.chk0.fail_cnt);
    if (dut0.chk0.fail_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

`default_nettype wire
